/* verilog/approxMultPkg.sv */
package approxMultPkg;

    localparam int OperandWidth = 8;
    localparam int ProductWidth = 16;
    localparam int AccCtrlWidth = 7;  // One bit per configurable adder cell

    typedef logic [OperandWidth-1:0] operand_t;
    typedef logic [ProductWidth-1:0] product_t;

    // Bit k set makes adder cell k (result bit 5+k) exact
    typedef logic [AccCtrlWidth-1:0] accCtrl_t;

    // Row j is operand A masked by bit j of operand B
    typedef operand_t [OperandWidth-1:0] ppRows_t;

    // Rows grow by the shift of each tree level
    typedef logic [OperandWidth:0]   row9_t;
    typedef logic [OperandWidth+2:0] row11_t;

    // Final level rows and overlap vectors
    typedef logic [ProductWidth-2:0] wideRow_t;

    typedef row9_t  [3:0] quadRow9_t;
    typedef row11_t [1:0] pairRow11_t;

    typedef struct packed {
        operand_t opA;
        operand_t opB;
        accCtrl_t accCtrl;
    } multReq_t;

endpackage

/* verilog/carryCompressor.sv */
module carryCompressor #(
    parameter int Width = 8,
    parameter int Shift = 1
) (
    input  logic [Width-1:0]       d1_i,
    input  logic [Width-1:0]       d2_i,
    output logic [Width+Shift-1:0] p_o,
    output logic [Width+Shift-1:0] q_o
);

    logic [Width+Shift-1:0] d2Shifted;

    assign d2Shifted = {d2_i, {Shift{1'b0}}};

    // Below the shift only the first row has bits
    assign p_o[Shift-1:0] = d1_i[Shift-1:0];
    assign q_o[Shift-1:0] = '0;

    // Ones present in both rows of the overlap window go to the Q row
    assign p_o[Width-1:Shift] = d1_i[Width-1:Shift] | d2Shifted[Width-1:Shift];
    assign q_o[Width-1:Shift] = d1_i[Width-1:Shift] & d2Shifted[Width-1:Shift];

    assign p_o[Width+Shift-1:Width] = d2Shifted[Width+Shift-1:Width];  // Shifted row only
    assign q_o[Width+Shift-1:Width] = '0;

endmodule

/* verilog/compressorTree8.sv */
module compressorTree8
    import approxMultPkg::*;
(
    input  ppRows_t   ppRows_i,
    output quadRow9_t sumRows_o,
    output wideRow_t  overlap_o
);

    quadRow9_t overlapRows;

    // Pairs (0,1) (2,3) (4,5) (6,7)
    for (genvar k = 0; k < 4; k++)
    begin : gCell
        carryCompressor #(
            .Width(OperandWidth),
            .Shift(1)
        ) i_cell (
            .d1_i(ppRows_i[2*k]),
            .d2_i(ppRows_i[2*k+1]),
            .p_o (sumRows_o[k]),
            .q_o (overlapRows[k])
        );
    end

    // Each pair sits two bits above the previous one
    always_comb
    begin
        overlap_o = '0;
        for (int k = 0; k < 4; k++)
        begin
            overlap_o = overlap_o | (wideRow_t'(overlapRows[k]) << (2 * k));
        end
    end

endmodule

/* verilog/compressorTree4.sv */
module compressorTree4
    import approxMultPkg::*;
(
    input  quadRow9_t  sumRows_i,
    output pairRow11_t sumRows_o,
    output wideRow_t   overlap_o
);

    pairRow11_t overlapRows;

    for (genvar k = 0; k < 2; k++)
    begin : gCell
        carryCompressor #(
            .Width($bits(row9_t)),
            .Shift(2)
        ) i_cell (
            .d1_i(sumRows_i[2*k]),
            .d2_i(sumRows_i[2*k+1]),
            .p_o (sumRows_o[k]),
            .q_o (overlapRows[k])
        );
    end

    // Second pair is four bits up
    assign overlap_o = wideRow_t'(overlapRows[0]) | (wideRow_t'(overlapRows[1]) << 4);

endmodule

/* verilog/accuracyAdder.sv */
module accuracyAdder
    import approxMultPkg::*;
(
    input  wideRow_t p7_i,
    input  wideRow_t q7_i,
    input  wideRow_t v1_i,
    input  wideRow_t v2_i,
    input  accCtrl_t accCtrl_i,
    output product_t product_o
);

    wideRow_t orPp;
    wideRow_t sumS;
    wideRow_t carryC;

    logic [AccCtrlWidth-1:0] chainSum;
    logic [AccCtrlWidth:0]   chainCarry;

    assign orPp = v1_i | v2_i;  // Only bits 4..10 feed the counters

    // Counter stage
    always_comb
    begin
        sumS   = '0;
        carryC = '0;

        sumS[0] = p7_i[0];
        {carryC[2], sumS[1]} = p7_i[1] + v1_i[1];

        for (int i = 2; i <= 12; i++)
        begin
            if (i >= 4 && i <= 10)
            begin
                {carryC[i+1], sumS[i]} = p7_i[i] + q7_i[i] + orPp[i];
            end
            else
            begin
                {carryC[i+1], sumS[i]} = p7_i[i] + v1_i[i] + v2_i[i];
            end
        end

        {carryC[14], sumS[13]} = p7_i[13] + v1_i[13];
        sumS[14] = p7_i[14];
    end

    assign chainCarry[0] = 1'b0;

    // Error-configurable cells on result bits 5..11
    for (genvar k = 0; k < AccCtrlWidth; k++)
    begin : gChain
        logic a;
        logic b;
        logic cin;
        logic halfSum;

        assign a       = sumS[5+k];
        assign b       = carryC[5+k];
        assign cin     = chainCarry[k];
        assign halfSum = a ^ b;

        always_comb
        begin
            if (accCtrl_i[k])
            begin
                chainSum[k]     = halfSum ^ cin;
                chainCarry[k+1] = (a & b) | (halfSum & cin);
            end
            else
            begin
                chainSum[k]     = halfSum | cin;  // Approximate mode
                chainCarry[k+1] = a & (b | cin);
            end
        end
    end

    always_comb
    begin
        logic rippleCarry;

        product_o[1:0]  = sumS[1:0];
        product_o[4:2]  = sumS[4:2] | carryC[4:2];  // Low bits take OR instead of add
        product_o[11:5] = chainSum;

        // Exact top ripple
        rippleCarry = chainCarry[AccCtrlWidth];
        for (int i = 12; i <= 14; i++)
        begin
            {rippleCarry, product_o[i]} = sumS[i] + carryC[i] + rippleCarry;
        end
        product_o[15] = rippleCarry;
    end

endmodule

/* verilog/approxMultCore.sv */
module approxMultCore
    import approxMultPkg::*;
(
    input  operand_t opA_i,
    input  operand_t opB_i,
    input  accCtrl_t accCtrl_i,
    output product_t product_o
);

    ppRows_t    ppRows;
    quadRow9_t  level1Rows;
    pairRow11_t level2Rows;
    wideRow_t   v1;
    wideRow_t   v2;
    wideRow_t   p7;
    wideRow_t   q7;

    // Partial products
    for (genvar j = 0; j < OperandWidth; j++)
    begin : gPp
        assign ppRows[j] = opA_i & {OperandWidth{opB_i[j]}};
    end

    compressorTree8 i_tree8 (
        .ppRows_i (ppRows),
        .sumRows_o(level1Rows),
        .overlap_o(v1)
    );

    compressorTree4 i_tree4 (
        .sumRows_i(level1Rows),
        .sumRows_o(level2Rows),
        .overlap_o(v2)
    );

    // Last level joins the two remaining rows
    carryCompressor #(
        .Width($bits(row11_t)),
        .Shift(4)
    ) i_finalCompressor (
        .d1_i(level2Rows[0]),
        .d2_i(level2Rows[1]),
        .p_o (p7),
        .q_o (q7)
    );

    accuracyAdder i_adder (
        .p7_i     (p7),
        .q7_i     (q7),
        .v1_i     (v1),
        .v2_i     (v2),
        .accCtrl_i(accCtrl_i),
        .product_o(product_o)
    );

endmodule

/* verilog/approxMultTop.sv */
module approxMultTop
    import approxMultPkg::*;
(
    input  logic     clk_i,
    input  logic     rstN_i,
    input  multReq_t req_i,
    input  logic     reqValid_i,
    output product_t product_o,
    output logic     productValid_o
);

    multReq_t reqReg;
    logic     reqValidReg;
    product_t coreProduct;
    product_t productReg;
    logic     productValidReg;

    always_ff @(posedge clk_i)
    begin
        if (!rstN_i)
        begin
            reqValidReg     <= 1'b0;
            productValidReg <= 1'b0;
        end
        else
        begin
            reqValidReg     <= reqValid_i;
            productValidReg <= reqValidReg;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reqValid_i)
            reqReg <= req_i;
        if (reqValidReg)
            productReg <= coreProduct;  // Holds when idle
    end

    approxMultCore i_core (
        .opA_i    (reqReg.opA),
        .opB_i    (reqReg.opB),
        .accCtrl_i(reqReg.accCtrl),
        .product_o(coreProduct)
    );

    assign product_o      = productReg;
    assign productValid_o = productValidReg;

    // Every accepted request gives one result two cycles later
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        productValid_o == ($past(reqValid_i & rstN_i, 2) & $past(rstN_i)))
        else $error("productValid_o does not follow reqValid_i by two cycles");

    assert property (@(posedge clk_i) disable iff (!rstN_i)
        productValid_o |-> !$isunknown(product_o))
        else $error("Unknown product while valid");

endmodule

/* test/approxMultModel.svh */
`ifndef APPROX_MULT_MODEL_SVH
`define APPROX_MULT_MODEL_SVH

// One carry-free cell on rows held in 16-bit vectors
function automatic void compressRows(
    input  logic [15:0] d1,
    input  logic [15:0] d2,
    input  int          width,
    input  int          shift,
    output logic [15:0] p,
    output logic [15:0] q
);
    logic d1Bit;
    logic d2Bit;

    p = '0;
    q = '0;
    for (int i = 0; i < width + shift; i++)
    begin
        d1Bit = 1'b0;
        d2Bit = 1'b0;
        if (i < width)
            d1Bit = d1[i];
        if (i >= shift)
            d2Bit = d2[i-shift];

        if (i < shift)
            p[i] = d1Bit;
        else if (i >= width)
            p[i] = d2Bit;
        else
        begin
            p[i] = d1Bit | d2Bit;
            q[i] = d1Bit & d2Bit;  // Overlap row
        end
    end
endfunction

function automatic product_t modelProduct(
    input operand_t a,
    input operand_t b,
    input accCtrl_t ctrl
);
    logic [15:0] pp [8];
    logic [15:0] row1 [4];
    logic [15:0] row2 [2];
    logic [15:0] ovl [4];
    logic [15:0] v1;
    logic [15:0] v2;
    logic [15:0] p7;
    logic [15:0] q7;
    logic [15:0] s;
    logic [15:0] c;
    logic        x;
    logic        y;
    logic        z;
    logic        carry;
    product_t    r;

    for (int j = 0; j < 8; j++)
        pp[j] = b[j] ? {8'h00, a} : 16'h0000;

    v1 = '0;
    for (int k = 0; k < 4; k++)
    begin
        compressRows(pp[2*k], pp[2*k+1], 8, 1, row1[k], ovl[k]);
        v1 = v1 | (ovl[k] << (2 * k));
    end

    compressRows(row1[0], row1[1], 9, 2, row2[0], ovl[0]);
    compressRows(row1[2], row1[3], 9, 2, row2[1], ovl[1]);
    v2 = ovl[0] | (ovl[1] << 4);
    compressRows(row2[0], row2[1], 11, 4, p7, q7);

    // Counter stage
    s = '0;
    c = '0;
    s[0] = p7[0];
    s[1] = p7[1] ^ v1[1];
    c[2] = p7[1] & v1[1];
    for (int i = 2; i <= 12; i++)
    begin
        x = p7[i];
        if (i >= 4 && i <= 10)
        begin
            y = q7[i];
            z = v1[i] | v2[i];
        end
        else
        begin
            y = v1[i];
            z = v2[i];
        end
        s[i]   = x ^ y ^ z;
        c[i+1] = (x & y) | (x & z) | (y & z);
    end
    s[13] = p7[13] ^ v1[13];
    c[14] = p7[13] & v1[13];
    s[14] = p7[14];

    r[1:0] = s[1:0];
    r[4:2] = s[4:2] | c[4:2];

    carry = 1'b0;
    for (int i = 5; i <= 14; i++)
    begin
        x = s[i];
        y = c[i];
        if (i > 11 || ctrl[i-5])
        begin
            r[i]  = x ^ y ^ carry;
            carry = (x & y) | (x & carry) | (y & carry);
        end
        else
        begin
            r[i]  = (x ^ y) | carry;  // Approximate cell
            carry = x & (y | carry);
        end
    end
    r[15] = carry;
    return r;
endfunction

`endif

/* test/approxMultTb.sv */
module approxMultTb
    import approxMultPkg::*;
();

    localparam int ClkPeriod        = 10;
    localparam int ExactRequests    = 8 * 3 + 4;
    localparam int AccuracyRequests = 3 * (2 + AccCtrlWidth);
    localparam int BurstRequests    = 300;
    localparam int GapRequests      = 20;
    localparam int TotalRequests    = ExactRequests + 1 + AccuracyRequests + BurstRequests
                                      + GapRequests;
    localparam int WatchdogCycles   = TotalRequests * 10 + 200;

    logic     clk;
    logic     rstN;
    multReq_t req;
    logic     reqValid;
    product_t product;
    logic     productValid;

    product_t    expectedQ [$];
    logic [31:0] lcgState      = 32'h0dff579b;
    int          valueErrors   = 0;
    int          missingErrors = 0;
    int          requestsSent  = 0;

    `include "approxMultModel.svh"

    approxMultTop i_dut (
        .clk_i         (clk),
        .rstN_i        (rstN),
        .req_i         (req),
        .reqValid_i    (reqValid),
        .product_o     (product),
        .productValid_o(productValid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic operand_t randomByte();
        logic [31:0] r;
        r = nextRandom();
        return r[31:24];  // Upper bits have the longest period
    endfunction

    function automatic accCtrl_t randomCtrl();
        logic [31:0] r;
        r = nextRandom();
        return r[31:25];
    endfunction

    task automatic checkProduct(input product_t expected, input product_t actual,
                                input string name);
        if (actual !== expected)
        begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkValid(input logic expected, input logic actual, input string name);
        if (actual !== expected)
        begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic sendRequest(input operand_t a, input operand_t b, input accCtrl_t ctrl,
                               input product_t expected);
        @(posedge clk);
        req.opA     <= a;
        req.opB     <= b;
        req.accCtrl <= ctrl;
        reqValid    <= 1'b1;
        expectedQ.push_back(expected);
        requestsSent++;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        reqValid <= 1'b0;
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        while (expectedQ.size() != 0 && waited < 10)
        begin
            @(posedge clk);
            waited++;
        end
        if (expectedQ.size() != 0)
        begin
            $display("%0d expected result(s) never came out of the DUT", expectedQ.size());
            missingErrors += expectedQ.size();
            expectedQ.delete();
        end
    endtask

    // Scoreboard checks each result at the falling edge
    always @(negedge clk)
    begin
        if (rstN && productValid === 1'b1)
        begin
            if (expectedQ.size() == 0)
            begin
                $display("productValid_o went high with no request outstanding");
                missingErrors++;
            end
            else
                checkProduct(expectedQ.pop_front(), product, "product_o");
        end
    end

    task automatic testReset();
        for (int i = 0; i < 9; i++)
        begin
            @(negedge clk);
            checkValid(1'b0, productValid, "productValid_o");
        end
        @(posedge clk);
        rstN <= 1'b1;  // Tenth rising edge still sees reset
        repeat (4)
        begin
            @(negedge clk);
            checkValid(1'b0, productValid, "productValid_o");
        end
    endtask

    task automatic testExactCases();
        operand_t aValues [3];
        operand_t opB;
        aValues[0] = 8'hff;
        aValues[1] = 8'h5a;
        aValues[2] = randomByte();
        for (int k = 0; k < 3; k++)
        begin
            for (int j = 0; j < OperandWidth; j++)
            begin
                opB = operand_t'(1) << j;
                sendRequest(aValues[k], opB, randomCtrl(), product_t'(aValues[k]) * opB);
            end
        end
        sendRequest(8'h00, 8'hff, randomCtrl(), '0);
        sendRequest(8'hff, 8'h00, randomCtrl(), '0);
        sendRequest(8'h00, 8'h00, randomCtrl(), '0);
        sendRequest(randomByte(), 8'h00, randomCtrl(), '0);
        idleCycle();
        drainResults();
    endtask

    task automatic testLatency();
        sendRequest(8'h2b, 8'h19, 7'h7f, modelProduct(8'h2b, 8'h19, 7'h7f));
        @(negedge clk);
        checkValid(1'b0, productValid, "productValid_o");
        idleCycle();
        @(negedge clk);
        checkValid(1'b0, productValid, "productValid_o");
        @(negedge clk);
        checkValid(1'b1, productValid, "productValid_o");
        @(negedge clk);
        checkValid(1'b0, productValid, "productValid_o");
        drainResults();
    endtask

    task automatic testAccuracyModes();
        operand_t opAs [3];
        operand_t opBs [3];
        accCtrl_t ctrls [2+AccCtrlWidth];
        opAs[0] = 8'hff;
        opBs[0] = 8'hff;
        opAs[1] = 8'hb7;
        opBs[1] = 8'h6d;
        opAs[2] = 8'h3c;
        opBs[2] = 8'hd9;
        ctrls[0] = '1;
        ctrls[1] = '0;
        for (int k = 0; k < AccCtrlWidth; k++)
            ctrls[2+k] = accCtrl_t'(1) << k;
        for (int p = 0; p < 3; p++)
        begin
            for (int m = 0; m < 2 + AccCtrlWidth; m++)
                sendRequest(opAs[p], opBs[p], ctrls[m], modelProduct(opAs[p], opBs[p], ctrls[m]));
        end
        idleCycle();
        drainResults();
    endtask

    task automatic testBackToBack();
        operand_t a;
        operand_t b;
        accCtrl_t ctrl;
        int       gap;
        for (int n = 0; n < BurstRequests + GapRequests; n++)
        begin
            a    = randomByte();
            b    = randomByte();
            ctrl = randomCtrl();
            sendRequest(a, b, ctrl, modelProduct(a, b, ctrl));
            if (n >= BurstRequests)
            begin
                gap = randomByte() % 4;  // Up to three idle cycles
                repeat (gap) idleCycle();
            end
        end
        idleCycle();
        drainResults();
    endtask

    initial
    begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles", WatchdogCycles);
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        rstN     = 1'b0;
        reqValid = 1'b0;
        req      = '0;

        testReset();
        testExactCases();
        testLatency();
        testAccuracyModes();
        testBackToBack();

        $display("Requests: %0d, value errors: %0d, missing or unexpected results: %0d",
                 requestsSent, valueErrors, missingErrors);
        if (valueErrors == 0 && missingErrors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* approxMult.f */
+incdir+test
verilog/approxMultPkg.sv
verilog/carryCompressor.sv
verilog/compressorTree8.sv
verilog/compressorTree4.sv
verilog/accuracyAdder.sv
verilog/approxMultCore.sv
verilog/approxMultTop.sv
test/approxMultTb.sv

/* Bender.yml */
package:
  name: approxMult

sources:
  - verilog/approxMultPkg.sv
  - verilog/carryCompressor.sv
  - verilog/compressorTree8.sv
  - verilog/compressorTree4.sv
  - verilog/accuracyAdder.sv
  - verilog/approxMultCore.sv
  - verilog/approxMultTop.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/approxMultTb.sv
